// ==== source/sp_consts.svh ====
`ifndef SP_CONSTS_SVH
`define SP_CONSTS_SVH

`default_nettype none

// ------------------------------------------------------------
// address map
// ------------------------------------------------------------
`define SP_REGION_NARROW 8'h80   // top byte of the narrow bus window
`define SP_REGION_REGS   8'hFF   // top byte of the register block

// local RAM geometry
`define SP_RAM_WORDS 256
`define SP_RAM_AW    8

// register block word offsets
`define SP_REG_CTRL    0
`define SP_REG_SCRATCH 1
`define SP_REG_NCOUNT  2

`default_nettype wire

`endif

// ==== source/sp_host_pkg.sv ====
`default_nettype none

package sp_host_pkg;

   typedef logic [31:0] addr_t;   // byte address
   typedef logic [31:0] word_t;
   typedef logic [3:0]  sel_t;    // bit 3 enables bits 31:24

   // ------------------------------------------------------------
   // host port, request held until ack
   // ------------------------------------------------------------
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      sel_t  sel;
      addr_t adr;
      word_t wdata;
   } host_req_t;

   typedef struct packed {
      logic  ack;
      word_t rdata;   // valid in the ack cycle
   } host_rsp_t;

   typedef enum logic [1:0] {
      RAM,
      NARROW,
      REGS,
      NONE
   } region_t;

endpackage

`default_nettype wire

// ==== source/sp_narrow_pkg.sv ====
`default_nettype none

package sp_narrow_pkg;

   typedef logic [7:0]  nbyte_t;
   typedef logic [23:0] nadr_t;   // word address bits 23:2, then lane
   typedef logic [1:0]  lane_t;   // lane 0 is the most significant byte

   typedef struct packed {
      logic   cyc;
      logic   stb;
      logic   we;
      logic   sel;
      nadr_t  adr;
      nbyte_t wdata;
   } narrow_req_t;

   typedef enum logic [1:0] {
      IDLE,
      XFER,
      DONE
   } bridge_state_t;

endpackage

`default_nettype wire

// ==== source/sp_region_decode.sv ====
`timescale 1ns/1ns
`include "sp_consts.svh"
`default_nettype none

module sp_region_decode (
   input  wire logic                   clk,
   input  wire logic                   rst_i,
   input  wire sp_host_pkg::host_req_t host_req_i,
   input  wire sp_host_pkg::host_rsp_t ram_rsp_i,
   input  wire sp_host_pkg::host_rsp_t narrow_rsp_i,
   input  wire sp_host_pkg::host_rsp_t regs_rsp_i,
   output sp_host_pkg::host_rsp_t      host_rsp_o,
   output logic                        ram_stb_o,
   output logic                        narrow_stb_o,
   output logic                        regs_stb_o
);

   sp_host_pkg::region_t region;
   logic                 host_stb;
   logic                 none_stb;
   logic                 none_ack_q;

   always_comb begin
      if (!host_req_i.adr[31]) begin
         region = sp_host_pkg::RAM;
      end else if (host_req_i.adr[31:24] == `SP_REGION_NARROW) begin
         region = sp_host_pkg::NARROW;
      end else if (host_req_i.adr[31:24] == `SP_REGION_REGS) begin
         region = sp_host_pkg::REGS;
      end else begin
         region = sp_host_pkg::NONE;
      end
   end

   assign host_stb     = host_req_i.cyc & host_req_i.stb;
   assign ram_stb_o    = host_stb & (region == sp_host_pkg::RAM);
   assign narrow_stb_o = host_stb & (region == sp_host_pkg::NARROW);
   assign regs_stb_o   = host_stb & (region == sp_host_pkg::REGS);
   assign none_stb     = host_stb & (region == sp_host_pkg::NONE);

   // unmapped space answers by itself so the host never stalls
   always_ff @(posedge clk) begin
      if (rst_i) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= none_stb & ~none_ack_q;   // one pulse per request
      end
   end

   always_comb begin
      case (region)
         sp_host_pkg::RAM:    host_rsp_o = ram_rsp_i;
         sp_host_pkg::NARROW: host_rsp_o = narrow_rsp_i;
         sp_host_pkg::REGS:   host_rsp_o = regs_rsp_i;
         default:             host_rsp_o = '{ack: none_ack_q, rdata: '0};
      endcase
   end

endmodule

`default_nettype wire

// ==== source/sp_bridge_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_bridge_ctrl (
   input  wire logic clk,
   input  wire logic rst_i,
   input  wire logic start_i,
   input  wire logic narrow_ack_i,
   input  wire logic last_lane_i,
   output logic      lane_adv_o,
   output logic      lane_clr_o,
   output logic      narrow_active_o,
   output logic      host_ack_o,
   output logic      done_o
);

   sp_narrow_pkg::bridge_state_t state_q;
   sp_narrow_pkg::bridge_state_t state_d;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= sp_narrow_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ------------------------------------------------------------
   // next state and outputs
   // ------------------------------------------------------------
   always_comb begin
      state_d         = state_q;
      lane_adv_o      = 1'b0;
      lane_clr_o      = 1'b0;
      narrow_active_o = 1'b0;
      host_ack_o      = 1'b0;
      done_o          = 1'b0;
      case (state_q)
         sp_narrow_pkg::IDLE: begin
            if (start_i) begin
               state_d = sp_narrow_pkg::XFER;
            end
         end
         sp_narrow_pkg::XFER: begin
            narrow_active_o = 1'b1;
            if (!start_i) begin
               state_d    = sp_narrow_pkg::IDLE;   // host abandoned the word
               lane_clr_o = 1'b1;
            end else if (narrow_ack_i) begin
               lane_adv_o = 1'b1;
               if (last_lane_i) begin
                  state_d = sp_narrow_pkg::DONE;
               end
            end
         end
         sp_narrow_pkg::DONE: begin
            host_ack_o = 1'b1;
            done_o     = 1'b1;
            lane_clr_o = 1'b1;
            state_d    = sp_narrow_pkg::IDLE;
         end
         default: begin
            state_d = sp_narrow_pkg::IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== source/sp_lane_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_lane_counter (
   input  wire logic            clk,
   input  wire logic            rst_i,
   input  wire logic            adv_i,
   input  wire logic            clr_i,
   output sp_narrow_pkg::lane_t lane_o,
   output logic                 last_o
);

   sp_narrow_pkg::lane_t lane_q;

   always_ff @(posedge clk) begin
      if (rst_i || clr_i) begin
         lane_q <= '0;
      end else if (adv_i) begin
         lane_q <= lane_q + 2'd1;   // wraps after lane 3
      end
   end

   assign lane_o = lane_q;
   assign last_o = (lane_q == 2'd3);

endmodule

`default_nettype wire

// ==== source/sp_byte_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_byte_shifter (
   input  wire logic                 clk,
   input  wire logic                 rst_i,
   input  wire sp_host_pkg::word_t   wdata_i,
   input  wire sp_narrow_pkg::lane_t lane_i,
   input  wire logic                 capture_i,
   input  wire sp_narrow_pkg::nbyte_t rbyte_i,
   output sp_narrow_pkg::nbyte_t     wbyte_o,
   output sp_host_pkg::word_t        rword_o
);

   sp_host_pkg::word_t shift_q;

   // ------------------------------------------------------------
   // write path, lane 0 carries bits 31:24
   // ------------------------------------------------------------
   always_comb begin
      case (lane_i)
         2'd0:    wbyte_o = wdata_i[31:24];
         2'd1:    wbyte_o = wdata_i[23:16];
         2'd2:    wbyte_o = wdata_i[15:8];
         default: wbyte_o = wdata_i[7:0];
      endcase
   end

   // ------------------------------------------------------------
   // read path
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_i) begin
         shift_q <= '0;
      end else if (capture_i) begin
         shift_q <= {shift_q[23:0], rbyte_i};   // first byte ends up on top
      end
   end

   assign rword_o = shift_q;

endmodule

`default_nettype wire

// ==== source/sp_local_ram.sv ====
`timescale 1ns/1ns
`include "sp_consts.svh"
`default_nettype none

module sp_local_ram (
   input  wire logic                   clk,
   input  wire logic                   rst_i,
   input  wire logic                   stb_i,
   input  wire sp_host_pkg::host_req_t req_i,
   output sp_host_pkg::host_rsp_t      rsp_o
);

   sp_host_pkg::word_t       mem [0:`SP_RAM_WORDS-1];
   logic [`SP_RAM_AW-1:0]    idx;
   logic                     access;
   logic                     ack_q;
   sp_host_pkg::word_t       rdata_q;

   assign idx    = req_i.adr[`SP_RAM_AW+1:2];
   assign access = stb_i & ~ack_q;   // no second ack while stb is still held

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdata_q <= mem[idx];
         if (req_i.we) begin
            for (int b = 0; b < 4; b++) begin
               if (req_i.sel[b]) begin
                  mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
            end
         end
      end
   end

   assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== source/sp_regs.sv ====
`timescale 1ns/1ns
`include "sp_consts.svh"
`default_nettype none

module sp_regs (
   input  wire logic                   clk,
   input  wire logic                   rst_i,
   input  wire logic                   stb_i,
   input  wire sp_host_pkg::host_req_t req_i,
   input  wire logic                   narrow_done_i,
   output sp_host_pkg::host_rsp_t      rsp_o,
   output logic                        led_green_o,
   output logic                        led_red_o,
   output logic [4:0]                  sw_reset_o
);

   logic [6:0]         ctrl_q;   // sw_reset, red, green
   sp_host_pkg::word_t scratch_q;
   sp_host_pkg::word_t ncount_q;
   sp_host_pkg::word_t rdata_q;
   logic               ack_q;
   logic               access;
   logic [21:0]        offset;

   assign offset = req_i.adr[23:2];
   assign access = stb_i & ~ack_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q     <= 1'b0;
         ctrl_q    <= '0;
         scratch_q <= '0;
      end else begin
         ack_q <= access;
         if (access && req_i.we) begin
            if (offset == 22'(`SP_REG_CTRL) && req_i.sel[0]) begin
               ctrl_q <= req_i.wdata[6:0];
            end
            if (offset == 22'(`SP_REG_SCRATCH)) begin
               for (int b = 0; b < 4; b++) begin
                  if (req_i.sel[b]) begin
                     scratch_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                  end
               end
            end
         end
      end
   end

   // completed narrow words
   always_ff @(posedge clk) begin
      if (rst_i) begin
         ncount_q <= '0;
      end else if (narrow_done_i) begin
         ncount_q <= ncount_q + 32'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (offset == 22'(`SP_REG_CTRL)) begin
            rdata_q <= {25'd0, ctrl_q};
         end else if (offset == 22'(`SP_REG_SCRATCH)) begin
            rdata_q <= scratch_q;
         end else if (offset == 22'(`SP_REG_NCOUNT)) begin
            rdata_q <= ncount_q;
         end else begin
            rdata_q <= '0;
         end
      end
   end

   assign rsp_o       = '{ack: ack_q, rdata: rdata_q};
   assign led_green_o = ctrl_q[0];
   assign led_red_o   = ctrl_q[1];
   assign sw_reset_o  = ctrl_q[6:2];

endmodule

`default_nettype wire

// ==== source/sp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_top (
   input  wire logic                   clk,
   input  wire logic                   rst_i,
   input  wire sp_host_pkg::host_req_t host_req_i,
   input  wire logic                   narrow_ack_i,
   input  wire sp_narrow_pkg::nbyte_t  narrow_rdata_i,
   output sp_host_pkg::host_rsp_t      host_rsp_o,
   output sp_narrow_pkg::narrow_req_t  narrow_req_o,
   output logic                        led_green_o,
   output logic                        led_red_o,
   output logic [4:0]                  sw_reset_o
);

   sp_host_pkg::host_rsp_t ram_rsp;
   sp_host_pkg::host_rsp_t narrow_rsp;
   sp_host_pkg::host_rsp_t regs_rsp;
   logic                   ram_stb;
   logic                   narrow_stb;
   logic                   regs_stb;
   logic                   lane_adv;
   logic                   lane_clr;
   logic                   last_lane;
   logic                   narrow_active;
   logic                   bridge_ack;
   logic                   bridge_done;
   sp_narrow_pkg::lane_t   lane;
   sp_narrow_pkg::nbyte_t  wbyte;
   sp_host_pkg::word_t     rword;

   sp_region_decode u_decode (
      .clk          (clk),
      .rst_i        (rst_i),
      .host_req_i   (host_req_i),
      .ram_rsp_i    (ram_rsp),
      .narrow_rsp_i (narrow_rsp),
      .regs_rsp_i   (regs_rsp),
      .host_rsp_o   (host_rsp_o),
      .ram_stb_o    (ram_stb),
      .narrow_stb_o (narrow_stb),
      .regs_stb_o   (regs_stb)
   );

   // ------------------------------------------------------------
   // narrow bus bridge
   // ------------------------------------------------------------
   sp_bridge_ctrl u_bridge (
      .clk             (clk),
      .rst_i           (rst_i),
      .start_i         (narrow_stb),
      .narrow_ack_i    (narrow_ack_i),
      .last_lane_i     (last_lane),
      .lane_adv_o      (lane_adv),
      .lane_clr_o      (lane_clr),
      .narrow_active_o (narrow_active),
      .host_ack_o      (bridge_ack),
      .done_o          (bridge_done)
   );

   sp_lane_counter u_lane (
      .clk    (clk),
      .rst_i  (rst_i),
      .adv_i  (lane_adv),
      .clr_i  (lane_clr),
      .lane_o (lane),
      .last_o (last_lane)
   );

   sp_byte_shifter u_shift (
      .clk       (clk),
      .rst_i     (rst_i),
      .wdata_i   (host_req_i.wdata),
      .lane_i    (lane),
      .capture_i (lane_adv),   // every narrow ack brings one byte
      .rbyte_i   (narrow_rdata_i),
      .wbyte_o   (wbyte),
      .rword_o   (rword)
   );

   assign narrow_req_o = '{cyc:   narrow_active,
                           stb:   narrow_active,
                           we:    host_req_i.we,
                           sel:   host_req_i.sel[~lane],
                           adr:   {host_req_i.adr[23:2], lane},
                           wdata: wbyte};
   assign narrow_rsp   = '{ack: bridge_ack, rdata: rword};

   // ------------------------------------------------------------
   // local targets
   // ------------------------------------------------------------
   sp_local_ram u_ram (
      .clk   (clk),
      .rst_i (rst_i),
      .stb_i (ram_stb),
      .req_i (host_req_i),
      .rsp_o (ram_rsp)
   );

   sp_regs u_regs (
      .clk           (clk),
      .rst_i         (rst_i),
      .stb_i         (regs_stb),
      .req_i         (host_req_i),
      .narrow_done_i (bridge_done),
      .rsp_o         (regs_rsp),
      .led_green_o   (led_green_o),
      .led_red_o     (led_red_o),
      .sw_reset_o    (sw_reset_o)
   );

endmodule

`default_nettype wire

// ==== sim/sp_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_sva (
   input wire logic                       clk,
   input wire logic                       rst_i,
   input wire sp_host_pkg::host_rsp_t     host_rsp_i,
   input wire sp_narrow_pkg::narrow_req_t narrow_req_i,
   input wire logic                       narrow_ack_i,
   input wire sp_host_pkg::host_rsp_t     ram_rsp_i,
   input wire sp_host_pkg::host_rsp_t     narrow_rsp_i,
   input wire sp_host_pkg::host_rsp_t     regs_rsp_i
);

   int sva_errors = 0;   // failed assertion count, read by the testbench

   // ------------------------------------------------------------
   // handshake rules
   // ------------------------------------------------------------
   ack_single_cycle: assert property (@(posedge clk) disable iff (rst_i)
      host_rsp_i.ack |=> !host_rsp_i.ack)
   else begin
      sva_errors++;
      $error("host ack high for two consecutive cycles");
   end

   // a byte request stays on the bus, inside cyc, until the slave acks it
   narrow_stb_held: assert property (@(posedge clk) disable iff (rst_i)
      narrow_req_i.stb && !narrow_ack_i |=>
         narrow_req_i.stb && narrow_req_i.cyc && $stable(narrow_req_i.adr))
   else begin
      sva_errors++;
      $error("narrow stb dropped or narrow address changed before the narrow ack");
   end

   target_ack_onehot: assert property (@(posedge clk) disable iff (rst_i)
      $onehot0({ram_rsp_i.ack, narrow_rsp_i.ack, regs_rsp_i.ack}))
   else begin
      sva_errors++;
      $error("more than one target ack in the same cycle");
   end

endmodule

bind sp_top sp_sva u_sva (
   .clk          (clk),
   .rst_i        (rst_i),
   .host_rsp_i   (host_rsp_o),
   .narrow_req_i (narrow_req_o),
   .narrow_ack_i (narrow_ack_i),
   .ram_rsp_i    (ram_rsp),
   .narrow_rsp_i (narrow_rsp),
   .regs_rsp_i   (regs_rsp)
);

`default_nettype wire

// ==== sim/sp_checker.sv ====
`timescale 1ns/1ns
`include "sp_consts.svh"
`default_nettype none

module sp_checker (
   input  wire logic                       clk,
   input  wire logic                       rst_i,
   input  wire sp_host_pkg::host_req_t     host_req_i,
   input  wire sp_host_pkg::host_rsp_t     host_rsp_i,
   input  wire sp_narrow_pkg::narrow_req_t narrow_req_i,
   input  wire logic                       narrow_ack_i,
   input  wire sp_narrow_pkg::nbyte_t      narrow_rdata_i,
   input  wire logic                       led_green_i,
   input  wire logic                       led_red_i,
   input  wire logic [4:0]                 sw_reset_i,
   output int                              checks_o,
   output int                              errors_o,
   output int                              acks_o
);

   sp_host_pkg::word_t ram_m [0:`SP_RAM_WORDS-1];
   logic [3:0]         ram_v [0:`SP_RAM_WORDS-1];   // bytes written since reset
   logic [6:0]         ctrl_m;
   sp_host_pkg::word_t scratch_m;
   sp_host_pkg::word_t ncount_m;
   sp_host_pkg::word_t nword_m;
   int                 nlanes;
   int                 stb_cycles;
   logic               four_done_q;   // fourth narrow ack seen in the previous cycle

   initial begin
      checks_o = 0;
      errors_o = 0;
      acks_o   = 0;
   end

   function automatic sp_host_pkg::region_t region_of(sp_host_pkg::addr_t adr);
      if (!adr[31]) return sp_host_pkg::RAM;
      if (adr[31:24] == `SP_REGION_NARROW) return sp_host_pkg::NARROW;
      if (adr[31:24] == `SP_REGION_REGS) return sp_host_pkg::REGS;
      return sp_host_pkg::NONE;
   endfunction

   task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
      checks_o++;
      if (got !== exp) begin
         errors_o++;
         $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_problem(string what);
      errors_o++;
      $display("ERROR at %0t ns: %s", $time, what);
   endtask

   task automatic reset_model();
      for (int i = 0; i < `SP_RAM_WORDS; i++) begin
         ram_v[i] = 4'h0;
      end
      ctrl_m      = '0;
      scratch_m   = '0;
      ncount_m    = '0;
      nword_m     = '0;
      nlanes      = 0;
      stb_cycles  = 0;
      four_done_q = 1'b0;
   endtask

   // ------------------------------------------------------------
   // host response at ack
   // ------------------------------------------------------------
   task automatic check_ack();
      sp_host_pkg::region_t rg;
      sp_host_pkg::word_t   mask;
      sp_host_pkg::word_t   exp;
      int                   idx;
      int                   off;
      rg  = region_of(host_req_i.adr);
      idx = host_req_i.adr[9:2];
      off = host_req_i.adr[23:2];
      acks_o++;
      if (rg != sp_host_pkg::NARROW) begin
         compare_value("host ack latency in stb cycles", stb_cycles, 2);
      end
      case (rg)
         sp_host_pkg::RAM: begin
            if (host_req_i.we) begin
               for (int b = 0; b < 4; b++) begin
                  if (host_req_i.sel[b]) begin
                     ram_m[idx][8*b +: 8] = host_req_i.wdata[8*b +: 8];
                     ram_v[idx][b]        = 1'b1;
                  end
               end
            end else begin
               for (int b = 0; b < 4; b++) begin
                  mask[8*b +: 8] = {8{ram_v[idx][b]}};   // unwritten bytes are unknown
               end
               compare_value("host_rsp_o.rdata", host_rsp_i.rdata & mask, ram_m[idx] & mask);
            end
         end
         sp_host_pkg::NARROW: begin
            compare_value("narrow transfers per word", nlanes, 4);
            if (!four_done_q) begin
               report_problem("narrow host ack did not come right after the fourth narrow ack");
            end
            if (!host_req_i.we) begin
               compare_value("host_rsp_o.rdata", host_rsp_i.rdata, nword_m);
            end
            ncount_m++;
            nlanes = 0;
         end
         sp_host_pkg::REGS: begin
            if (host_req_i.we) begin
               if (off == `SP_REG_CTRL && host_req_i.sel[0]) begin
                  ctrl_m = host_req_i.wdata[6:0];
               end
               if (off == `SP_REG_SCRATCH) begin
                  for (int b = 0; b < 4; b++) begin
                     if (host_req_i.sel[b]) begin
                        scratch_m[8*b +: 8] = host_req_i.wdata[8*b +: 8];
                     end
                  end
               end
            end else begin
               case (off)
                  `SP_REG_CTRL:    exp = {25'd0, ctrl_m};
                  `SP_REG_SCRATCH: exp = scratch_m;
                  `SP_REG_NCOUNT:  exp = ncount_m;
                  default:         exp = '0;
               endcase
               compare_value("host_rsp_o.rdata", host_rsp_i.rdata, exp);
            end
         end
         default: begin
            compare_value("host_rsp_o.rdata", host_rsp_i.rdata, 32'd0);
         end
      endcase
   endtask

   // one accepted byte transfer on the narrow bus
   task automatic check_lane();
      int l;
      l = nlanes;
      if (l >= 4) begin
         report_problem("more than four narrow transfers for one host word");
         return;
      end
      compare_value("narrow_req_o.adr", narrow_req_i.adr, {host_req_i.adr[23:2], 2'(l)});
      compare_value("narrow_req_o.we", narrow_req_i.we, host_req_i.we);
      compare_value("narrow_req_o.sel", narrow_req_i.sel, host_req_i.sel[3-l]);
      if (host_req_i.we) begin
         compare_value("narrow_req_o.wdata", narrow_req_i.wdata,
                       host_req_i.wdata[31-8*l -: 8]);
      end
      nword_m[31-8*l -: 8] = narrow_rdata_i;   // lane 0 byte lands in 31:24
      nlanes++;
   endtask

   always @(negedge clk) begin
      if (rst_i) begin
         reset_model();
      end else begin
         if (host_req_i.cyc && host_req_i.stb) begin
            stb_cycles++;
         end else begin
            stb_cycles = 0;
         end
         if (host_rsp_i.ack) begin
            if (host_req_i.cyc && host_req_i.stb) begin
               check_ack();
            end else begin
               report_problem("host ack without a pending request");
            end
         end
         four_done_q = 1'b0;
         if (narrow_req_i.cyc && narrow_req_i.stb && narrow_ack_i) begin
            check_lane();
            four_done_q = (nlanes == 4);
         end
         if (narrow_req_i.cyc && !(host_req_i.cyc && host_req_i.stb &&
             region_of(host_req_i.adr) == sp_host_pkg::NARROW)) begin
            report_problem("narrow bus active without a narrow host request");
         end
         compare_value("led_green_o", led_green_i, ctrl_m[0]);
         compare_value("led_red_o", led_red_i, ctrl_m[1]);
         compare_value("sw_reset_o", sw_reset_i, ctrl_m[6:2]);
      end
   end

endmodule

`default_nettype wire

// ==== sim/sp_tb.sv ====
`timescale 1ns/1ns
`include "sp_consts.svh"
`default_nettype none

module sp_tb;

   localparam int NUM_TRANS     = 400;
   localparam int RESET_CYCLES  = 4;
   localparam int TIMEOUT_LIMIT = NUM_TRANS * 12 + RESET_CYCLES;

   logic                       clk;
   logic                       rst_i;
   sp_host_pkg::host_req_t     host_req;
   sp_host_pkg::host_rsp_t     host_rsp;
   sp_narrow_pkg::narrow_req_t narrow_req;
   logic                       narrow_ack;
   sp_narrow_pkg::nbyte_t      narrow_rdata;
   logic                       led_green;
   logic                       led_red;
   logic [4:0]                 sw_reset;
   int                         check_count;
   int                         error_count;
   int                         ack_count;
   int                         cycle_count = 0;
   int                         slave_wait;
   int                         lane_delay [4];   // per lane ack delay of the next narrow word
   sp_narrow_pkg::nbyte_t      lane_byte [4];

   sp_top dut0 (
      .clk            (clk),
      .rst_i          (rst_i),
      .host_req_i     (host_req),
      .narrow_ack_i   (narrow_ack),
      .narrow_rdata_i (narrow_rdata),
      .host_rsp_o     (host_rsp),
      .narrow_req_o   (narrow_req),
      .led_green_o    (led_green),
      .led_red_o      (led_red),
      .sw_reset_o     (sw_reset)
   );

   sp_checker u_checker (
      .clk            (clk),
      .rst_i          (rst_i),
      .host_req_i     (host_req),
      .host_rsp_i     (host_rsp),
      .narrow_req_i   (narrow_req),
      .narrow_ack_i   (narrow_ack),
      .narrow_rdata_i (narrow_rdata),
      .led_green_i    (led_green),
      .led_red_i      (led_red),
      .sw_reset_i     (sw_reset),
      .checks_o       (check_count),
      .errors_o       (error_count),
      .acks_o         (ack_count)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ------------------------------------------------------------
   // narrow bus slave
   // ------------------------------------------------------------
   always @(posedge clk) begin
      if (rst_i) begin
         narrow_ack   <= 1'b0;
         narrow_rdata <= '0;
         slave_wait   <= 0;
      end else if (narrow_ack || !(narrow_req.cyc && narrow_req.stb)) begin
         narrow_ack <= 1'b0;   // one ack per byte request
         slave_wait <= 0;
      end else if (slave_wait >= lane_delay[narrow_req.adr[1:0]]) begin
         narrow_ack   <= 1'b1;
         narrow_rdata <= lane_byte[narrow_req.adr[1:0]];
         slave_wait   <= 0;
      end else begin
         slave_wait <= slave_wait + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_LIMIT) begin
         $display("timeout after %0d cycles with %0d of %0d host transactions done",
                  cycle_count, ack_count, NUM_TRANS);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic pick_request(output sp_host_pkg::host_req_t req);
      int unsigned kind;
      logic [31:0] r;
      kind      = $urandom_range(3);
      r         = $urandom;
      req       = '0;
      req.cyc   = 1'b1;
      req.stb   = 1'b1;
      req.we    = 1'($urandom);
      req.sel   = 4'($urandom);
      req.wdata = $urandom;
      case (kind)
         0: req.adr = {1'b0, r[30:10], 3'b000, r[4:0], 2'b00};   // 32 RAM words, upper bits alias
         1: req.adr = {`SP_REGION_NARROW, r[23:2], 2'b00};
         2: req.adr = {`SP_REGION_REGS, 20'd0, r[1:0], 2'b00};  // offsets 0 to 3
         default: req.adr = {8'h81 + 8'($urandom_range(125)), r[23:0]};
      endcase
      for (int l = 0; l < 4; l++) begin
         lane_delay[l] = $urandom_range(3);
         lane_byte[l]  = 8'($urandom);
      end
   endtask

   // ------------------------------------------------------------
   // host stimulus
   // ------------------------------------------------------------
   initial begin
      sp_host_pkg::host_req_t req;
      void'($urandom(32'h2cc4_1b49));
      host_req     <= '0;
      narrow_ack   <= 1'b0;
      narrow_rdata <= '0;
      rst_i        <= 1'b1;
      for (int l = 0; l < 4; l++) begin
         lane_delay[l] = 0;
         lane_byte[l]  = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst_i <= 1'b0;
      for (int n = 0; n < NUM_TRANS; n++) begin
         @(posedge clk);
         pick_request(req);
         host_req <= req;
         do @(posedge clk); while (!host_rsp.ack);
         host_req.cyc <= 1'b0;   // request ends with the ack cycle
         host_req.stb <= 1'b0;
      end
      repeat (3) @(posedge clk);
      $display("checks %0d, errors %0d, assertion failures %0d, host acks %0d",
               check_count, error_count, dut0.u_sva.sva_errors, ack_count);
      if (error_count == 0 && dut0.u_sva.sva_errors == 0 && ack_count == NUM_TRANS) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+source
source/sp_host_pkg.sv
source/sp_narrow_pkg.sv
source/sp_region_decode.sv
source/sp_bridge_ctrl.sv
source/sp_lane_counter.sv
source/sp_byte_shifter.sv
source/sp_local_ram.sv
source/sp_regs.sv
source/sp_top.sv
sim/sp_sva.sv
sim/sp_checker.sv
sim/sp_tb.sv
